// ==== tests/acq_input.txt ====
# num_bursts pre_trig trig_delay credit_delay
# a line repeating the num_bursts and pre_trig of the line before queues behind it
1 0 5 1
4 8 20 3
8 32 10 8
16 16 12 2
16 16 3 2
2 120 30 5
12 40 15 7
12 40 2 1
30 4 10 8

// ==== compile.f ====
hw/acq_pkg.sv
hw/sample_capture.sv
hw/circ_buffer.sv
hw/trig_addr_fifo.sv
hw/acq_sequencer.sv
hw/frame_builder.sv
hw/adc_acq_top.sv
tests/adc_acq_assertions.sv
tests/tb_adc_acq.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_adc_acq
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_adc_acq.sv ====
`default_nettype none

module tb_adc_acq;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          WARMUP    = 130;          // longer than the largest pre_trig
    localparam logic [23:0] FILL_INIT = 24'hfffffe;   // fill number wraps after two waveforms
    localparam logic [11:0] CHAN      = 12'h5a3;

    typedef struct {
        int          id;     // line number among the tests
        int          nb;
        int          pre;
        int          cd;     // credit return delay in cycles
        int          t;      // write count of the trigger word
        logic [23:0] fill;
    } wfm_t;

    logic                                adc_clk = 1'b0;
    logic                                rst;
    logic [acq_pkg::SAMPLE_W-1:0]        sample_a;
    logic [acq_pkg::SAMPLE_W-1:0]        sample_b;
    logic                                ovr_a;
    logic                                ovr_b;
    logic                                acq_enable;
    logic                                trig;
    logic [acq_pkg::CHAN_TAG_W-1:0]      channel_tag;
    logic [acq_pkg::BURSTS_W-1:0]        num_bursts;
    logic [acq_pkg::PRE_TRIG_W-1:0]      pre_trig;
    logic [acq_pkg::FILL_NUM_W-1:0]      initial_fill_num;
    logic                                fill_num_wr;
    logic                                credit_return;
    logic [acq_pkg::OUT_W-1:0]           out_data;
    logic                                out_valid;
    logic [acq_pkg::FILL_NUM_W-1:0]      fill_num;
    logic                                acq_idle;

    logic [15:0]                     lfsr = 16'd14;
    logic [acq_pkg::CBUF_WORD_W-1:0] hist[$];        // every buffer word, by write count
    wfm_t                            wfm_q[$];       // waveforms still expected, trigger order
    int                              credit_due[$];  // cycle at which each credit goes back
    int                              nb_l[$];
    int                              pre_l[$];
    int                              dly_l[$];
    int                              cd_l[$];

    int cyc          = 0;
    int word_idx     = 0;    // 0 is the header
    int words_seen   = 0;
    int credits_back = 0;
    int wfm_errs     = 0;
    int checks       = 0;
    int errors       = 0;
    int wd_cycles    = 0;

    adc_acq_top UUT (
        .adc_clk, .rst, .sample_a, .sample_b, .ovr_a, .ovr_b, .acq_enable, .trig,
        .channel_tag, .num_bursts, .pre_trig, .initial_fill_num, .fill_num_wr,
        .credit_return, .out_data, .out_valid, .fill_num, .acq_idle
    );

    always #4 adc_clk = ~adc_clk;   // 8 ns

    ////////////////////////////////////////////////////////////
    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic next_rand_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_rand_bit()};   // one step per bit
        end
        return v;
    endfunction

    // expected header from the format rules
    function automatic logic [acq_pkg::OUT_W-1:0] header_word(input wfm_t w);
        logic [acq_pkg::PAYLOAD_W-1:0] p;
        p        = '0;
        p[23:0]  = w.fill;
        p[35:24] = CHAN;
        p[49:36] = 14'(w.nb);
        p[65:50] = 16'(w.pre);
        p[73:66] = 8'(w.t);          // trigger address is the write count mod 256
        return {4'(acq_pkg::TAG_WFM_HDR), p};
    endfunction

    // data word k holds four words from pre_trig before the trigger, oldest lowest
    function automatic logic [acq_pkg::OUT_W-1:0] data_word(input wfm_t w, input int k);
        logic [acq_pkg::PAYLOAD_W-1:0] p;
        int                            s;
        p = '0;
        s = w.t - w.pre + acq_pkg::WORDS_PER_BURST * k;
        for (int j = 0; j < acq_pkg::WORDS_PER_BURST; j++) begin
            p[acq_pkg::CBUF_WORD_W*j +: acq_pkg::CBUF_WORD_W] = hist[s + j];
        end
        return {4'(acq_pkg::TAG_DATA), p};
    endfunction

    // drive one sample pair at the falling edge, then move to the next one
    task automatic step(input logic trig_val);
        logic [acq_pkg::SAMPLE_W-1:0]    sa;
        logic [acq_pkg::SAMPLE_W-1:0]    sb;
        logic                            oa;
        logic                            ob;
        logic [acq_pkg::CBUF_WORD_W-1:0] wd;
        sa       = 12'(rand_bits(12));
        sb       = 12'(rand_bits(12));
        oa       = next_rand_bit();
        ob       = next_rand_bit();
        sample_a = sa;
        sample_b = sb;
        ovr_a    = oa;
        ovr_b    = ob;
        trig     = trig_val;
        wd        = '0;
        wd[0]     = oa;                  // over-range a in bit 0
        wd[12:1]  = sa;
        wd[13]    = ob;
        wd[25:14] = sb;                  // sample b on top
        hist.push_back(wd);
        @(negedge adc_clk);
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor and downstream credit model
    always @(negedge adc_clk) begin
        wfm_t                      w;
        logic [acq_pkg::OUT_W-1:0] exp_word;
        int                        cd;
        int                        due;
        if (rst) begin
            credit_return = 1'b0;
        end else begin
            cyc++;
            if (out_valid === 1'b1) begin
                checks++;
                if (words_seen - credits_back >= acq_pkg::OUT_CREDITS) begin
                    errors++;
                    $display("ERR %0t: word sent with %0d words already outstanding",
                             $time, words_seen - credits_back);
                end
                words_seen++;
                cd  = (wfm_q.size() != 0) ? wfm_q[0].cd : 1;
                due = cyc + cd;
                // downstream drains one word every cd cycles, a backlog stalls the DUT
                if (credit_due.size() != 0 && credit_due[$] + cd > due) begin
                    due = credit_due[$] + cd;
                end
                credit_due.push_back(due);
                if (wfm_q.size() == 0) begin
                    errors++;
                    $display("output word %h arrived with no waveform pending", out_data);
                end else begin
                    w = wfm_q[0];
                    if (word_idx == 0) begin
                        wfm_errs = errors;
                        exp_word = header_word(w);
                    end else begin
                        exp_word = data_word(w, word_idx - 1);
                    end
                    checks++;
                    if (out_data !== exp_word) begin
                        errors++;
                        $display("ERR %0t: test %0d word %0d got %h expected %h",
                                 $time, w.id, word_idx, out_data, exp_word);
                    end
                    if (word_idx == w.nb) begin   // last word of this waveform
                        checks++;
                        if (acq_idle !== 1'b1) begin
                            errors++;
                            $display("ERR %0t: test %0d acq_idle low after last word",
                                     $time, w.id);
                        end
                        checks++;
                        if (fill_num !== w.fill + 24'd1) begin   // bumped by the last word
                            errors++;
                            $display("ERR %0t: test %0d fill_num %h expected %h",
                                     $time, w.id, fill_num, w.fill + 24'd1);
                        end
                        $display("test %0d: num_bursts=%0d pre_trig=%0d credit_delay=%0d %s",
                                 w.id, w.nb, w.pre, w.cd,
                                 (errors == wfm_errs) ? "ok" : "mismatch");
                        void'(wfm_q.pop_front());
                        word_idx = 0;
                    end else begin
                        word_idx++;
                    end
                end
            end
            // at most one credit back per cycle
            if (credit_due.size() != 0 && credit_due[0] <= cyc) begin
                credit_return = 1'b1;
                void'(credit_due.pop_front());
                credits_back++;
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    initial begin
        int    fd;
        int    a;
        int    b;
        int    c;
        int    d;
        int    sum;
        string line;
        wfm_t  nw;
        rst              = 1'b1;
        sample_a         = '0;
        sample_b         = '0;
        ovr_a            = 1'b0;
        ovr_b            = 1'b0;
        acq_enable       = 1'b0;
        trig             = 1'b0;
        channel_tag      = CHAN;
        num_bursts       = '0;
        pre_trig         = '0;
        initial_fill_num = '0;
        fill_num_wr      = 1'b0;
        credit_return    = 1'b0;
        sum              = 0;

        fd = $fopen("tests/acq_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/acq_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && $sscanf(line, "%d %d %d %d", a, b, c, d) == 4) begin
                    nb_l.push_back(a);
                    pre_l.push_back(b);
                    dly_l.push_back(c);
                    cd_l.push_back(d);
                    sum += c + 20 + a * (8 + d);   // rough cycles per waveform
                end
            end
            $fclose(fd);
        end
        if (nb_l.size() == 0) begin
            $display("no tests found in tests/acq_input.txt");
            errors++;
        end
        wd_cycles = 2 * (WARMUP + 100 + sum);

        repeat (2) @(posedge adc_clk);
        @(negedge adc_clk);
        rst              = 1'b0;
        acq_enable       = 1'b1;
        fill_num_wr      = 1'b1;   // load the fill counter once
        initial_fill_num = FILL_INIT;
        step(1'b0);
        fill_num_wr = 1'b0;
        repeat (WARMUP) step(1'b0);   // fill the buffer for the pre-trigger reads

        for (int i = 0; i < nb_l.size(); i++) begin
            // same settings as the line before means the trigger queues behind it
            if (i == 0 || nb_l[i] != nb_l[i-1] || pre_l[i] != pre_l[i-1]) begin
                while (wfm_q.size() != 0) begin
                    step(1'b0);
                end
                num_bursts = 14'(nb_l[i]);
                pre_trig   = 16'(pre_l[i]);
            end
            repeat (dly_l[i]) step(1'b0);
            nw.id   = i;
            nw.nb   = nb_l[i];
            nw.pre  = pre_l[i];
            nw.cd   = cd_l[i];
            nw.t    = hist.size();          // index of the word written with trig high
            nw.fill = FILL_INIT + 24'(i);
            wfm_q.push_back(nw);
            step(1'b1);
        end
        while (wfm_q.size() != 0) begin
            step(1'b0);
        end
        repeat (20) step(1'b0);   // a stray word would show up here

        if (UUT.u_chk.fail_count != 0) begin
            $display("bound assertions failed %0d times", UUT.u_chk.fail_count);
            errors++;
        end
        $display("summary: tests=%0d checks=%0d errors=%0d", nb_l.size(), checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // watchdog
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge adc_clk);
        $display("timeout after %0d cycles with %0d waveforms still pending",
                 wd_cycles, wfm_q.size());
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/adc_acq_assertions.sv ====
`default_nettype none

module adc_acq_assertions (
    input wire logic                         adc_clk,
    input wire logic                         rst,
    input wire logic                         out_valid,
    input wire logic                         acq_idle,
    input wire logic                         credit_return,
    input wire logic [acq_pkg::CREDIT_W-1:0] credit_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // read by the testbench at the end
    int run_words;        // words since the last credit return

    always @(posedge adc_clk) begin
        if (rst) begin
            run_words <= 0;
        end else if (credit_return) begin
            run_words <= 0;
        end else if (out_valid) begin
            run_words <= run_words + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // a word was granted from a nonzero credit count
    credit_gate: assert property (@(posedge adc_clk) disable iff (rst)
        out_valid |-> $past(credit_cnt) != '0)
    else begin
        fail_count++;
        $error("output word sent while the credit count was zero");
    end

    idle_after_reset: assert property (@(posedge adc_clk) $fell(rst) |-> acq_idle)
    else begin
        fail_count++;
        $error("acq_idle low in the cycle after reset");
    end

    credit_run: assert property (@(posedge adc_clk) disable iff (rst)
        run_words <= acq_pkg::OUT_CREDITS)
    else begin
        fail_count++;
        $error("more output words than credits without a credit return");
    end

endmodule

bind adc_acq_top adc_acq_assertions u_chk (
    .adc_clk, .rst, .out_valid, .acq_idle, .credit_return,
    .credit_cnt (u_seq.credit_cnt)
);

`default_nettype wire

// ==== hw/adc_acq_top.sv ====
`default_nettype none

module adc_acq_top (
    input  wire logic                             adc_clk,
    input  wire logic                             rst,
    input  wire logic [acq_pkg::SAMPLE_W-1:0]     sample_a,
    input  wire logic [acq_pkg::SAMPLE_W-1:0]     sample_b,
    input  wire logic                             ovr_a,
    input  wire logic                             ovr_b,
    input  wire logic                             acq_enable,
    input  wire logic                             trig,
    input  wire logic [acq_pkg::CHAN_TAG_W-1:0]   channel_tag,
    input  wire logic [acq_pkg::BURSTS_W-1:0]     num_bursts,
    input  wire logic [acq_pkg::PRE_TRIG_W-1:0]   pre_trig,
    input  wire logic [acq_pkg::FILL_NUM_W-1:0]   initial_fill_num,
    input  wire logic                             fill_num_wr,
    input  wire logic                             credit_return,
    output logic [acq_pkg::OUT_W-1:0]             out_data,
    output logic                                  out_valid,
    output logic [acq_pkg::FILL_NUM_W-1:0]        fill_num,
    output logic                                  acq_idle
);

    // capture side
    logic                            wr_en;
    logic [acq_pkg::CBUF_ADDR_W-1:0] wr_addr;
    logic [acq_pkg::CBUF_WORD_W-1:0] wr_data;
    logic                            trig_push;
    logic [acq_pkg::CBUF_ADDR_W-1:0] trig_addr;

    // readout side
    logic [acq_pkg::CBUF_ADDR_W-1:0] rd_addr;
    logic [acq_pkg::CBUF_WORD_W-1:0] rd_data;
    logic [acq_pkg::CBUF_ADDR_W-1:0] head_addr;
    logic [acq_pkg::CBUF_ADDR_W-1:0] trig_addr_hdr;
    logic                            fifo_empty;
    logic                            fifo_pop;
    logic                            shift_en;
    logic                            emit_hdr;
    logic                            emit_dat;

    ////////////////////////////////////////////////////////////
    sample_capture u_capture (
        .adc_clk, .rst, .sample_a, .sample_b, .ovr_a, .ovr_b, .acq_enable, .trig,
        .wr_en, .wr_addr, .wr_data, .trig_push, .trig_addr
    );

    circ_buffer u_cbuf (
        .adc_clk, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_data
    );

    trig_addr_fifo u_fifo (
        .adc_clk, .rst,
        .push      (trig_push),
        .push_addr (trig_addr),
        .pop       (fifo_pop),
        .head_addr,
        .empty     (fifo_empty)
    );

    ////////////////////////////////////////////////////////////
    acq_sequencer u_seq (
        .adc_clk, .rst, .fifo_empty, .head_addr, .num_bursts, .pre_trig,
        .initial_fill_num, .fill_num_wr, .credit_return,
        .fifo_pop, .rd_addr, .shift_en, .emit_hdr, .emit_dat, .trig_addr_hdr,
        .fill_num, .acq_idle
    );

    frame_builder u_frame (
        .adc_clk, .rst, .rd_data, .shift_en, .emit_hdr, .emit_dat, .fill_num,
        .channel_tag, .num_bursts, .pre_trig, .trig_addr_hdr,
        .out_data, .out_valid
    );

endmodule

`default_nettype wire

// ==== hw/frame_builder.sv ====
`default_nettype none

module frame_builder (
    input  wire logic                             adc_clk,
    input  wire logic                             rst,
    input  wire logic [acq_pkg::CBUF_WORD_W-1:0]  rd_data,
    input  wire logic                             shift_en,
    input  wire logic                             emit_hdr,
    input  wire logic                             emit_dat,
    input  wire logic [acq_pkg::FILL_NUM_W-1:0]   fill_num,
    input  wire logic [acq_pkg::CHAN_TAG_W-1:0]   channel_tag,
    input  wire logic [acq_pkg::BURSTS_W-1:0]     num_bursts,
    input  wire logic [acq_pkg::PRE_TRIG_W-1:0]   pre_trig,
    input  wire logic [acq_pkg::CBUF_ADDR_W-1:0]  trig_addr_hdr,
    output logic [acq_pkg::OUT_W-1:0]             out_data,
    output logic                                  out_valid
);

    // gathering register, index 0 holds the oldest word once full
    logic [acq_pkg::WORDS_PER_BURST-1:0][acq_pkg::CBUF_WORD_W-1:0] gather;

    logic [acq_pkg::PAYLOAD_W-1:0] hdr_payload;
    logic [acq_pkg::PAYLOAD_W-1:0] dat_payload;

    ////////////////////////////////////////////////////////////
    // four-word shift in, new word enters at the top
    always_ff @(posedge adc_clk) begin
        if (shift_en) begin
            gather <= {rd_data, gather[acq_pkg::WORDS_PER_BURST-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // payload layouts
    always_comb begin
        hdr_payload        = '0;            // unused bits stay zero
        hdr_payload[23:0]  = fill_num;
        hdr_payload[35:24] = channel_tag;
        hdr_payload[49:36] = num_bursts;
        hdr_payload[65:50] = pre_trig;
        hdr_payload[73:66] = trig_addr_hdr;
    end

    always_comb begin
        dat_payload = '0;                   // top 24 bits zero
        dat_payload[acq_pkg::WORDS_PER_BURST*acq_pkg::CBUF_WORD_W-1:0] = gather;
    end

    ////////////////////////////////////////////////////////////
    // output mux and register
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit_hdr || emit_dat;   // single cycle per word
        end
    end

    always_ff @(posedge adc_clk) begin
        if (emit_hdr) begin
            out_data <= {acq_pkg::TAG_WFM_HDR, hdr_payload};
        end else if (emit_dat) begin
            out_data <= {acq_pkg::TAG_DATA, dat_payload};
        end
    end

endmodule

`default_nettype wire

// ==== hw/acq_sequencer.sv ====
`default_nettype none

module acq_sequencer (
    input  wire logic                             adc_clk,
    input  wire logic                             rst,
    input  wire logic                             fifo_empty,
    input  wire logic [acq_pkg::CBUF_ADDR_W-1:0]  head_addr,
    input  wire logic [acq_pkg::BURSTS_W-1:0]     num_bursts,
    input  wire logic [acq_pkg::PRE_TRIG_W-1:0]   pre_trig,
    input  wire logic [acq_pkg::FILL_NUM_W-1:0]   initial_fill_num,
    input  wire logic                             fill_num_wr,
    input  wire logic                             credit_return,
    output logic                                  fifo_pop,
    output logic [acq_pkg::CBUF_ADDR_W-1:0]       rd_addr,
    output logic                                  shift_en,
    output logic                                  emit_hdr,
    output logic                                  emit_dat,
    output logic [acq_pkg::CBUF_ADDR_W-1:0]       trig_addr_hdr,
    output logic [acq_pkg::FILL_NUM_W-1:0]        fill_num,
    output logic                                  acq_idle
);

    acq_pkg::seq_state_e state;
    acq_pkg::seq_state_e state_nxt;

    acq_pkg::credit_t                               credit_cnt;   // free slots downstream
    logic [acq_pkg::BURSTS_W-1:0]                   burst_cnt;    // bursts still to emit
    logic [acq_pkg::BURSTS_W-1:0]                   burst_left;
    logic [$clog2(acq_pkg::WORDS_PER_BURST)-1:0]    word_cnt;     // reads within a burst

    logic has_credit;
    logic last_word;
    logic fill_inc;

    ////////////////////////////////////////////////////////////
    // decode
    assign has_credit = credit_cnt != '0;
    assign last_word  = int'(word_cnt) == acq_pkg::WORDS_PER_BURST - 1;
    assign burst_left = burst_cnt - 1'b1;

    assign fifo_pop = state == acq_pkg::ST_POP;
    assign acq_idle = state == acq_pkg::ST_IDLE;
    assign emit_hdr = (state == acq_pkg::ST_HDR) && has_credit;
    // hold off while the last read of the burst is still shifting in
    assign emit_dat = (state == acq_pkg::ST_EMIT) && has_credit && !shift_en;

    // waveform done after its last data word, or at the header for zero bursts
    assign fill_inc = (emit_dat && burst_left == '0) || (emit_hdr && burst_cnt == '0);

    always_comb begin
        state_nxt = state;
        case (state)
            acq_pkg::ST_IDLE:   if (!fifo_empty) state_nxt = acq_pkg::ST_POP;
            acq_pkg::ST_POP:    state_nxt = acq_pkg::ST_START;
            acq_pkg::ST_START:  state_nxt = acq_pkg::ST_HDR;
            acq_pkg::ST_HDR: begin
                if (emit_hdr) begin
                    state_nxt = (burst_cnt == '0) ? acq_pkg::ST_IDLE : acq_pkg::ST_GATHER;
                end
            end
            acq_pkg::ST_GATHER: if (last_word) state_nxt = acq_pkg::ST_EMIT;
            acq_pkg::ST_EMIT: begin
                if (emit_dat) begin
                    state_nxt = (burst_left == '0) ? acq_pkg::ST_IDLE : acq_pkg::ST_GATHER;
                end
            end
            default:            state_nxt = acq_pkg::ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state, counters and credits
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            state      <= acq_pkg::ST_IDLE;
            credit_cnt <= acq_pkg::credit_t'(acq_pkg::OUT_CREDITS);
            rd_addr    <= '0;
            burst_cnt  <= '0;
            word_cnt   <= '0;
            shift_en   <= 1'b0;
        end else begin
            state    <= state_nxt;
            shift_en <= state == acq_pkg::ST_GATHER;   // read data lands one cycle later

            case ({credit_return, emit_hdr || emit_dat})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;      // spend and return cancel
            endcase

            case (state)
                acq_pkg::ST_START: begin
                    // start pre_trig words back, modulo the buffer depth
                    rd_addr   <= trig_addr_hdr - pre_trig[acq_pkg::CBUF_ADDR_W-1:0];
                    burst_cnt <= num_bursts;
                    word_cnt  <= '0;
                end
                acq_pkg::ST_GATHER: begin
                    rd_addr  <= rd_addr + 1'b1;
                    word_cnt <= word_cnt + 1'b1;       // wraps to 0 for the next burst
                end
                acq_pkg::ST_EMIT: begin
                    if (emit_dat) burst_cnt <= burst_left;
                end
                default: ;
            endcase
        end
    end

    // fill counter, loadable at any time
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            fill_num <= '0;
        end else if (fill_num_wr) begin
            fill_num <= initial_fill_num;
        end else if (fill_inc) begin
            fill_num <= fill_num + 1'b1;
        end
    end

    // trigger address for the header, taken as it leaves the FIFO
    always_ff @(posedge adc_clk) begin
        if (fifo_pop) begin
            trig_addr_hdr <= head_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/trig_addr_fifo.sv ====
`default_nettype none

module trig_addr_fifo (
    input  wire logic                             adc_clk,
    input  wire logic                             rst,
    input  wire logic                             push,
    input  wire logic [acq_pkg::CBUF_ADDR_W-1:0]  push_addr,
    input  wire logic                             pop,
    output logic [acq_pkg::CBUF_ADDR_W-1:0]       head_addr,
    output logic                                  empty
);

    logic [acq_pkg::CBUF_ADDR_W-1:0] mem [acq_pkg::TRIG_FIFO_DEPTH];

    logic [$clog2(acq_pkg::TRIG_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(acq_pkg::TRIG_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(acq_pkg::TRIG_FIFO_DEPTH+1)-1:0] count;   // entries held

    logic full;
    logic do_push;
    logic do_pop;

    assign full    = int'(count) == acq_pkg::TRIG_FIFO_DEPTH;
    assign empty   = count == '0;
    assign do_push = push && !full;    // trigger dropped when full
    assign do_pop  = pop && !empty;

    // first word falls through, no read latency
    assign head_addr = mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // none, or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge adc_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/circ_buffer.sv ====
`default_nettype none

module circ_buffer (
    input  wire logic                             adc_clk,
    input  wire logic                             wr_en,
    input  wire logic [acq_pkg::CBUF_ADDR_W-1:0]  wr_addr,
    input  wire logic [acq_pkg::CBUF_WORD_W-1:0]  wr_data,
    input  wire logic [acq_pkg::CBUF_ADDR_W-1:0]  rd_addr,
    output logic [acq_pkg::CBUF_WORD_W-1:0]       rd_data
);

    // simple dual port ram, maps onto block ram
    logic [acq_pkg::CBUF_WORD_W-1:0] mem [1 << acq_pkg::CBUF_ADDR_W];

    always_ff @(posedge adc_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;   // capture port
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge adc_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/sample_capture.sv ====
`default_nettype none

module sample_capture (
    input  wire logic                            adc_clk,
    input  wire logic                            rst,
    input  wire logic [acq_pkg::SAMPLE_W-1:0]    sample_a,
    input  wire logic [acq_pkg::SAMPLE_W-1:0]    sample_b,
    input  wire logic                            ovr_a,
    input  wire logic                            ovr_b,
    input  wire logic                            acq_enable,
    input  wire logic                            trig,
    output logic                                 wr_en,
    output logic [acq_pkg::CBUF_ADDR_W-1:0]      wr_addr,
    output logic [acq_pkg::CBUF_WORD_W-1:0]      wr_data,
    output logic                                 trig_push,
    output logic [acq_pkg::CBUF_ADDR_W-1:0]      trig_addr
);

    logic trig_d;       // trig from the previous cycle
    logic trig_edge;    // rising edge while enabled

    ////////////////////////////////////////////////////////////
    // write side of the circular buffer
    assign wr_en   = acq_enable;                           // one word per cycle while enabled
    assign wr_data = {sample_b, ovr_b, sample_a, ovr_a};   // ovr_a lands in bit 0

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (acq_enable) begin
            wr_addr <= wr_addr + 1'b1;                     // wraps at the buffer depth
        end
    end

    ////////////////////////////////////////////////////////////
    // trigger edge detect
    assign trig_edge = trig && !trig_d && acq_enable;

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            trig_d    <= 1'b0;
            trig_push <= 1'b0;
        end else begin
            trig_d    <= trig;
            trig_push <= trig_edge;                        // push lags the trigger by one cycle
        end
    end

    // address written in the trigger cycle, valid alongside trig_push
    always_ff @(posedge adc_clk) begin
        if (trig_edge) begin
            trig_addr <= wr_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/acq_pkg.sv ====
`default_nettype none

package acq_pkg;

    ////////////////////////////////////////////////////////////
    // sample and circular buffer geometry
    localparam int SAMPLE_W        = 12;   // one adc sample
    localparam int CBUF_WORD_W     = 26;   // two samples plus two over-range bits
    localparam int CBUF_ADDR_W     = 8;    // 256 buffer words
    localparam int TRIG_FIFO_DEPTH = 4;    // trigger addresses held for readout

    ////////////////////////////////////////////////////////////
    // readout word layout
    localparam int WORDS_PER_BURST = 4;    // buffer words per output data word, 8 samples
    localparam int PAYLOAD_W       = 128;
    localparam int OUT_W           = 132;  // 4-bit tag on top of the payload

    // header field widths
    localparam int FILL_NUM_W      = 24;
    localparam int BURSTS_W        = 14;
    localparam int PRE_TRIG_W      = 16;
    localparam int CHAN_TAG_W      = 12;

    ////////////////////////////////////////////////////////////
    // output flow control
    localparam int OUT_CREDITS     = 4;    // words the downstream FIFO can absorb
    localparam int CREDIT_W        = $clog2(OUT_CREDITS + 1);

    typedef logic [CREDIT_W-1:0] credit_t;

    // tag in the top nibble of every output word
    typedef enum logic [3:0] {
        TAG_WFM_HDR = 4'h1,
        TAG_DATA    = 4'h2
    } out_tag_e;

    // readout sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,    // waiting for a queued trigger
        ST_POP,     // take the trigger address off the FIFO
        ST_START,   // load start address and burst count
        ST_HDR,     // emit the waveform header when a credit is free
        ST_GATHER,  // read four buffer words
        ST_EMIT     // emit one data word when a credit is free
    } seq_state_e;

endpackage

`default_nettype wire
